// ==== design/data_req_queue.sv ====
// in-order data request FIFO: pointers, count, head outputs

`include "mem_port_cfg.svh"

module data_req_queue
    import mem_port_pkg::*;
(
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     req_valid,
    input  logic                     req_store,
    input  logic [`MP_XLEN-1:0]       req_addr,
    input  logic [`MP_XLEN-1:0]       req_data,
    input  logic                     head_pop,
    output logic                     req_ready,
    output logic                     head_valid,
    output bus_cmd_t                 head_cmd,
    output logic [`MP_XLEN-1:0]       head_addr,
    output logic [`MP_BLOCK_BITS-1:0] head_data
);

    localparam int PTR_W = $clog2(`MP_QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;
    localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(`MP_QUEUE_DEPTH - 1);

    // entry storage
    logic                      q_store [`MP_QUEUE_DEPTH];
    logic [`MP_XLEN-1:0]       q_addr  [`MP_QUEUE_DEPTH];
    logic [`MP_BLOCK_BITS-1:0] q_data  [`MP_QUEUE_DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             push;

    ////////////////////////////////////////////////////////////
    // core side
    ////////////////////////////////////////////////////////////

    assign req_ready = (count != CNT_W'(`MP_QUEUE_DEPTH));
    assign push      = req_valid && req_ready;

    always_ff @(posedge clock) begin
        if (push) begin
            q_store[tail] <= req_store;
            q_addr[tail]  <= req_addr;
            // word goes into the half selected by addr bit 2
            q_data[tail]  <= req_addr[2] ? {req_data, `MP_XLEN'(0)}
                                         : {`MP_XLEN'(0), req_data};
        end
    end

    ////////////////////////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= (tail == LAST_IDX) ? '0 : tail + 1'b1;
            end
            if (head_pop) begin
                head <= (head == LAST_IDX) ? '0 : head + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(head_pop);
        end
    end

    // head toward the arbiter
    assign head_valid = (count != '0);
    assign head_cmd   = !head_valid    ? BUS_NONE
                      : q_store[head] ? BUS_STORE
                      : BUS_LOAD;
    assign head_addr  = q_addr[head];
    assign head_data  = q_data[head];

    // arbiter pops only what it saw
    assert property (@(posedge clock) disable iff (reset) head_pop |-> count != '0);

endmodule

// ==== design/fetch_unit.sv ====
// sequential instruction fetch: pc, outstanding flag, instruction output register

`include "mem_port_cfg.svh"

module fetch_unit
    import mem_port_pkg::*;
(
    input  logic               clock,
    input  logic               reset,
    input  logic               fetch_grant,
    input  logic               fetch_return,
    input  mem_block_t         fetch_block,
    input  logic               inst_ready,
    output logic               fetch_req,
    output logic [`MP_XLEN-1:0] fetch_addr,
    output logic               inst_valid,
    output logic [`MP_XLEN-1:0] inst,
    output logic [`MP_XLEN-1:0] inst_pc
);

    logic [`MP_XLEN-1:0] pc;
    logic                waiting;
    logic                fetch_en;
    logic                out_free;

    ////////////////////////////////////////////////////////////
    // request side
    ////////////////////////////////////////////////////////////

    // output reg empty, or its word leaves this cycle
    assign out_free  = !inst_valid || inst_ready;

    // one request in flight at most
    assign fetch_req = fetch_en && !waiting && out_free;

    // block aligned address, the half is picked on return
    assign fetch_addr = {pc[`MP_XLEN-1:3], 3'b000};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            fetch_en <= 1'b0;
            waiting  <= 1'b0;
            pc       <= `MP_RESET_PC;
        end else begin
            // first request one cycle after reset drops
            fetch_en <= 1'b1;
            if (fetch_return) begin
                waiting <= 1'b0;
                pc      <= pc + `MP_XLEN'(4);
            end else if (fetch_grant) begin
                waiting <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // instruction output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            inst_valid <= 1'b0;
        end else if (fetch_return) begin
            inst_valid <= 1'b1;
        end else if (inst_ready) begin
            inst_valid <= 1'b0;
        end
    end

    // payload, loaded only on return
    always_ff @(posedge clock) begin
        if (fetch_return) begin
            inst    <= fetch_block.words[pc[2]];
            inst_pc <= pc;
        end
    end

    // consumer stall keeps the instruction in place
    assert property (@(posedge clock) disable iff (reset)
        inst_valid && !inst_ready |=> inst_valid && $stable(inst) && $stable(inst_pc));

endmodule

// ==== design/mem_arbiter.sv ====
// memory bus arbiter: data-first request mux, per-tag owner table, return routing

`include "mem_port_cfg.svh"

module mem_arbiter
    import mem_port_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      fetch_req,
    input  logic [`MP_XLEN-1:0]       fetch_addr,
    input  logic                      head_valid,
    input  bus_cmd_t                  head_cmd,
    input  logic [`MP_XLEN-1:0]       head_addr,
    input  logic [`MP_BLOCK_BITS-1:0] head_data,
    input  logic [`MP_TAG_BITS-1:0]   mem_response,
    input  logic [`MP_BLOCK_BITS-1:0] mem_rdata,
    input  logic [`MP_TAG_BITS-1:0]   mem_tag,
    output bus_cmd_t                  mem_command,
    output logic [`MP_XLEN-1:0]       mem_addr,
    output logic [`MP_BLOCK_BITS-1:0] mem_data,
    output logic                      fetch_grant,
    output logic                      head_pop,
    output logic                      fetch_return,
    output mem_block_t                fetch_block,
    output logic                      load_valid,
    output logic [`MP_XLEN-1:0]       load_data
);

    localparam int TAGS = 1 << `MP_TAG_BITS;

    // owner table, one slot per tag
    logic [TAGS-1:0] own_valid;
    logic [TAGS-1:0] own_fetch;
    logic [TAGS-1:0] own_upper;

    logic       accept;
    logic       ret_hit;
    mem_block_t ret_block;

    ////////////////////////////////////////////////////////////
    // request mux
    ////////////////////////////////////////////////////////////

    // data queue head wins over fetch
    always_comb begin
        if (head_valid) begin
            mem_command = head_cmd;
            mem_addr    = head_addr;
            mem_data    = head_data;
        end else begin
            mem_command = fetch_req ? BUS_LOAD : BUS_NONE;
            mem_addr    = fetch_addr;
            mem_data    = '0;
        end
    end

    // nonzero response is the new tag
    assign accept      = (mem_command != BUS_NONE) && (mem_response != '0);
    assign head_pop    = accept && head_valid;
    assign fetch_grant = accept && !head_valid;

    ////////////////////////////////////////////////////////////
    // owner table
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            own_valid <= '0;
        end else begin
            // retire first so a reused tag can be set in the same cycle
            if (ret_hit) begin
                own_valid[mem_tag] <= 1'b0;
            end
            if (accept && mem_command == BUS_LOAD) begin
                own_valid[mem_response] <= 1'b1;
            end
        end
    end

    // owner and offset only matter while the slot is valid
    always_ff @(posedge clock) begin
        if (accept && mem_command == BUS_LOAD) begin
            own_fetch[mem_response] <= !head_valid;
            own_upper[mem_response] <= mem_addr[2];
        end
    end

    ////////////////////////////////////////////////////////////
    // return routing
    ////////////////////////////////////////////////////////////

    assign ret_block.dword = mem_rdata;
    assign ret_hit         = (mem_tag != '0) && own_valid[mem_tag];

    assign fetch_return = ret_hit && own_fetch[mem_tag];
    assign fetch_block  = ret_block;

    // load word taken from the half it was issued for
    assign load_valid = ret_hit && !own_fetch[mem_tag];
    assign load_data  = ret_block.words[own_upper[mem_tag]];

    // memory only returns tags it handed out for loads
    assert property (@(posedge clock) disable iff (reset)
        mem_tag != '0 |-> own_valid[mem_tag]);

endmodule

// ==== design/mem_port_pkg.sv ====
// shared types: bus command encoding and memory block union

`include "mem_port_cfg.svh"

package mem_port_pkg;

    ////////////////////////////////////////////////////////////
    // bus command
    ////////////////////////////////////////////////////////////

    // encoding matches the memory model
    typedef enum logic [1:0] {
        BUS_NONE  = 2'b00,
        BUS_LOAD  = 2'b01,
        BUS_STORE = 2'b10
    } bus_cmd_t;

    ////////////////////////////////////////////////////////////
    // memory block
    ////////////////////////////////////////////////////////////

    // one 64-bit block, seen as two words or as one double word
    typedef union packed {
        // fetch view, word 0 is the lower address
        logic [`MP_BLOCK_BITS/`MP_XLEN-1:0][`MP_XLEN-1:0] words;
        // data view
        logic [`MP_BLOCK_BITS-1:0] dword;
    } mem_block_t;

endpackage

// ==== design/mem_port_top.sv ====
// top level: fetch unit, data request queue and arbiter on one memory bus

`include "mem_port_cfg.svh"

module mem_port_top
    import mem_port_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    // memory bus
    output bus_cmd_t                  mem_command,
    output logic [`MP_XLEN-1:0]       mem_addr,
    output logic [`MP_BLOCK_BITS-1:0] mem_data,
    input  logic [`MP_TAG_BITS-1:0]   mem_response,
    input  logic [`MP_BLOCK_BITS-1:0] mem_rdata,
    input  logic [`MP_TAG_BITS-1:0]   mem_tag,
    // core data requests
    input  logic                      req_valid,
    input  logic                      req_store,
    input  logic [`MP_XLEN-1:0]       req_addr,
    input  logic [`MP_XLEN-1:0]       req_data,
    output logic                      req_ready,
    // load results, in request order
    output logic                      load_valid,
    output logic [`MP_XLEN-1:0]       load_data,
    // instruction stream
    output logic                      inst_valid,
    output logic [`MP_XLEN-1:0]       inst,
    output logic [`MP_XLEN-1:0]       inst_pc,
    input  logic                      inst_ready
);

    ////////////////////////////////////////////////////////////
    // internal links
    ////////////////////////////////////////////////////////////

    // fetch unit and arbiter
    logic                fetch_req;
    logic [`MP_XLEN-1:0] fetch_addr;
    logic                fetch_grant;
    logic                fetch_return;
    mem_block_t          fetch_block;

    // queue head and arbiter
    logic                      head_valid;
    bus_cmd_t                  head_cmd;
    logic [`MP_XLEN-1:0]       head_addr;
    logic [`MP_BLOCK_BITS-1:0] head_data;
    logic                      head_pop;

    fetch_unit u_fetch (
        .clock        (clock),
        .reset        (reset),
        .fetch_grant  (fetch_grant),
        .fetch_return (fetch_return),
        .fetch_block  (fetch_block),
        .inst_ready   (inst_ready),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .inst_pc      (inst_pc)
    );

    data_req_queue u_queue (
        .clock      (clock),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_store  (req_store),
        .req_addr   (req_addr),
        .req_data   (req_data),
        .head_pop   (head_pop),
        .req_ready  (req_ready),
        .head_valid (head_valid),
        .head_cmd   (head_cmd),
        .head_addr  (head_addr),
        .head_data  (head_data)
    );

    // single owner of the memory bus
    mem_arbiter u_arbiter (
        .clock        (clock),
        .reset        (reset),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .head_valid   (head_valid),
        .head_cmd     (head_cmd),
        .head_addr    (head_addr),
        .head_data    (head_data),
        .mem_response (mem_response),
        .mem_rdata    (mem_rdata),
        .mem_tag      (mem_tag),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_data     (mem_data),
        .fetch_grant  (fetch_grant),
        .head_pop     (head_pop),
        .fetch_return (fetch_return),
        .fetch_block  (fetch_block),
        .load_valid   (load_valid),
        .load_data    (load_data)
    );

endmodule

// ==== include/mem_port_cfg.svh ====
// memory port configuration macros: widths, tag size, queue depth, reset pc

`ifndef MEM_PORT_CFG_SVH
`define MEM_PORT_CFG_SVH

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////

// address and instruction word
`define MP_XLEN 32

// one memory block, two instruction words
`define MP_BLOCK_BITS 64

////////////////////////////////////////////////////////////
// bus and queue sizing
////////////////////////////////////////////////////////////

// transaction tag, zero is reserved for no tag
`define MP_TAG_BITS 4

// data request entries, power of two
`define MP_QUEUE_DEPTH 4

// first instruction address after reset
`define MP_RESET_PC 32'h0000_0000

`endif

// ==== mem_port.f ====
+incdir+include
design/mem_port_pkg.sv
design/fetch_unit.sv
design/data_req_queue.sv
design/mem_arbiter.sv
design/mem_port_top.sv
verif/tb_checker.sv
verif/tb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the mem_port testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_top -f mem_port.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    exit 1
fi

exit 0

// ==== verif/tb_checker.sv ====
// testbench checker: reference memory word function, instruction and load comparison

`include "mem_port_cfg.svh"

module tb_checker
    import mem_port_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    input  bus_cmd_t            mem_command,
    input  logic                req_valid,
    input  logic                req_store,
    input  logic [`MP_XLEN-1:0] req_addr,
    input  logic [`MP_XLEN-1:0] req_data,
    input  logic                req_ready,
    input  logic                load_valid,
    input  logic [`MP_XLEN-1:0] load_data,
    input  logic                inst_valid,
    input  logic [`MP_XLEN-1:0] inst,
    input  logic [`MP_XLEN-1:0] inst_pc,
    input  logic                inst_ready,
    output int                  error_count,
    output int                  inst_count,
    output int                  load_count,
    output int                  loads_open
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] shadow [16];
    logic [31:0] expect_q [$];
    logic [31:0] exp_pc;
    logic [31:0] held_inst;
    logic [31:0] held_pc;
    logic        held;
    int          errors = 0;
    int          insts = 0;
    int          loads = 0;
    int          open_loads = 0;

    assign error_count = errors;
    assign inst_count  = insts;
    assign load_count  = loads;
    assign loads_open  = open_loads;

    // code below 0x1000, data words above it in request order
    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        if (addr < 32'h1000) begin
            return (addr ^ 32'h6d2b_79f5) * 32'h0001_0193 + addr;
        end
        return shadow[addr[5:2]];
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    always @(negedge clock) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                shadow[i] = (32'(32'h1000 + 4 * i) * 32'h2545_f491) ^ 32'h0f0f_3c3c;
            end
            exp_pc = `MP_RESET_PC;
            held   = 1'b0;
            compare_value("mem_command", 32'(mem_command), 32'(BUS_NONE));
            compare_value("inst_valid", 32'(inst_valid), 32'd0);
            compare_value("load_valid", 32'(load_valid), 32'd0);
            compare_value("req_ready", 32'(req_ready), 32'd1);
        end else begin
            // a load taken this cycle cannot complete yet
            if (load_valid) begin
                if (expect_q.size() == 0) begin
                    $display("load result arrived with no load outstanding at %0t", $time);
                    errors++;
                end else begin
                    compare_value("load_data", load_data, expect_q.pop_front());
                    loads++;
                end
            end
            if (req_valid && req_ready) begin
                if (req_store) begin
                    shadow[req_addr[5:2]] = req_data;
                end else begin
                    expect_q.push_back(ref_word(req_addr));
                end
            end
            // stalled instruction must not move
            if (held) begin
                compare_value("inst_valid", 32'(inst_valid), 32'd1);
                compare_value("inst", inst, held_inst);
                compare_value("inst_pc", inst_pc, held_pc);
            end
            held      = inst_valid && !inst_ready;
            held_inst = inst;
            held_pc   = inst_pc;
            if (inst_valid && inst_ready) begin
                compare_value("inst_pc", inst_pc, exp_pc);
                compare_value("inst", inst, ref_word(exp_pc));
                exp_pc = exp_pc + 32'd4;
                insts++;
            end
            open_loads = expect_q.size();
        end
    end

endmodule

// ==== verif/tb_top.sv ====
// testbench top: clock, reset, lcg, memory model, request stimulus, watchdog

`include "mem_port_cfg.svh"

module tb_top
    import mem_port_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD_NS = 40;
    localparam int NUM_REQS      = 60;
    localparam int NUM_INSTS     = 60;
    localparam int WATCHDOG_NS   = (NUM_REQS + NUM_INSTS) * 10 * CLK_PERIOD_NS;

    logic                      clock;
    logic                      reset;
    bus_cmd_t                  mem_command;
    logic [`MP_XLEN-1:0]       mem_addr;
    logic [`MP_BLOCK_BITS-1:0] mem_data;
    logic [`MP_TAG_BITS-1:0]   mem_response;
    logic [`MP_BLOCK_BITS-1:0] mem_rdata;
    logic [`MP_TAG_BITS-1:0]   mem_tag;
    logic                      req_valid;
    logic                      req_store;
    logic [`MP_XLEN-1:0]       req_addr;
    logic [`MP_XLEN-1:0]       req_data;
    logic                      req_ready;
    logic                      load_valid;
    logic [`MP_XLEN-1:0]       load_data;
    logic                      inst_valid;
    logic [`MP_XLEN-1:0]       inst;
    logic [`MP_XLEN-1:0]       inst_pc;
    logic                      inst_ready;
    int                        error_count;
    int                        inst_count;
    int                        load_count;
    int                        loads_open;

    // memory model state
    logic [31:0]               dmem [16];
    logic [`MP_TAG_BITS-1:0]   next_tag;
    logic [`MP_TAG_BITS-1:0]   ret_tag_q [$];
    logic [`MP_BLOCK_BITS-1:0] ret_data_q [$];
    int                        ret_due_q [$];
    int                        cyc;
    int                        last_due;
    int                        reqs_sent;
    logic                      req_taken;
    logic                      finished;
    logic [31:0]               seed;

    mem_port_top u_dut (.*);

    tb_checker u_checker (.*);

    always #(CLK_PERIOD_NS / 2) clock = ~clock;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // instruction region content
    function automatic logic [31:0] code_word(input logic [31:0] a);
        return (a ^ 32'h6d2b_79f5) * 32'h0001_0193 + a;
    endfunction

    function automatic logic [31:0] data_init(input logic [31:0] a);
        return (a * 32'h2545_f491) ^ 32'h0f0f_3c3c;
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] a);
        return (a < 32'h1000) ? code_word(a) : dmem[a[5:2]];
    endfunction

    // both halves of the block around a
    function automatic logic [63:0] model_block(input logic [31:0] a);
        mem_block_t blk;
        blk.words[0] = model_word({a[31:3], 3'b000});
        blk.words[1] = model_word({a[31:3], 3'b100});
        return blk.dword;
    endfunction

    ////////////////////////////////////////////////////////////
    // memory model and stimulus
    ////////////////////////////////////////////////////////////

    // settled bus of the current cycle, acceptance happens at the next edge
    task automatic sample_bus();
        int lat;
        req_taken = req_valid && req_ready;
        if (req_taken) begin
            reqs_sent++;
        end
        if (mem_command != BUS_NONE && mem_response != '0) begin
            if (mem_command == BUS_STORE) begin
                dmem[mem_addr[5:2]] = mem_addr[2] ? mem_data[63:32] : mem_data[31:0];
            end else begin
                seed = lcg_step(seed);
                lat = 2 + int'(seed[17:16]);
                // in order, at most one return per cycle
                last_due = (cyc + lat > last_due) ? cyc + lat : last_due + 1;
                ret_tag_q.push_back(mem_response);
                ret_data_q.push_back(model_block(mem_addr));
                ret_due_q.push_back(last_due);
            end
            next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        end
    endtask

    task automatic drive_inputs();
        cyc++;
        // accept about three cycles in four
        seed = lcg_step(seed);
        mem_response = (seed[17:16] != 2'b00) ? next_tag : '0;
        if (ret_due_q.size() != 0 && ret_due_q[0] <= cyc) begin
            mem_tag   = ret_tag_q.pop_front();
            mem_rdata = ret_data_q.pop_front();
            void'(ret_due_q.pop_front());
        end else begin
            mem_tag   = '0;
            mem_rdata = '0;
        end
        seed = lcg_step(seed);
        inst_ready = (seed[19:18] != 2'b00);
        // a request is held until taken
        if (req_taken || !req_valid) begin
            seed = lcg_step(seed);
            if (reqs_sent < NUM_REQS && seed[16]) begin
                req_valid = 1'b1;
                req_store = seed[17];
                // mostly a new word, sometimes the last one again
                if (seed[20:19] != 2'b00) begin
                    req_addr = 32'h0000_1000 | {26'd0, seed[24:21], 2'b00};
                end
                seed = lcg_step(seed);
                req_data = seed;
            end else begin
                req_valid = 1'b0;
            end
        end
    endtask

    initial begin
        seed         = 32'h8fe6;
        clock        = 1'b0;
        reset        = 1'b1;
        mem_response = '0;
        mem_rdata    = '0;
        mem_tag      = '0;
        req_valid    = 1'b0;
        req_store    = 1'b0;
        req_addr     = 32'h0000_1000;
        req_data     = '0;
        inst_ready   = 1'b0;
        next_tag     = 4'd1;
        cyc          = 0;
        last_due     = 0;
        reqs_sent    = 0;
        req_taken    = 1'b0;
        finished     = 1'b0;
        for (int i = 0; i < 16; i++) begin
            dmem[i] = data_init(32'h0000_1000 + 32'(4 * i));
        end
        repeat (3) @(posedge clock);
        #2 reset = 1'b0;
        while (!finished) begin
            @(negedge clock);
            sample_bus();
            @(posedge clock);
            #2;
            finished = (reqs_sent == NUM_REQS) && (loads_open == 0)
                     && (inst_count >= NUM_INSTS);
            if (!finished) begin
                drive_inputs();
            end
        end
        $display("checked %0d instructions and %0d loads, %0d errors",
                 inst_count, load_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // bounded run time
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: %0d of %0d requests sent, %0d loads without a result, %0d instructions",
                 reqs_sent, NUM_REQS, loads_open, inst_count);
        $display("Some tests failed");
        $finish;
    end

endmodule
